// File: Makefile
# Verilator build and run for rvExec

VERILATOR ?= verilator
TOP       ?= tbRvExec
FILELIST  ?= rvExec.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIMARGS   ?= +verilator+error+limit+100
PASS_MSG  ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) $(SIMARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: common/rvPkg.sv
`default_nettype none

package rvPkg;

    // data width is fixed by the RV32I instruction format
    localparam int xlen = 32;

    // widest pc any instance may use, sizes the pc fields in the stage payloads
    localparam int pcMaxW = 32;

    typedef logic [xlen-1:0] wordT;
    typedef logic [4:0]      regAddrT;
    typedef logic [31:0]     instrT;

    // funct3 of a conditional branch
    typedef logic [2:0] branchCodeT;

    // major opcodes that are decoded, everything else is a no-op
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opBranch = 7'b1100011;

    // encoding is {instr[30], funct3} so the decoder can cast it straight across
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSll  = 4'b0001,
        aluSlt  = 4'b0010,
        aluSltu = 4'b0011,
        aluXor  = 4'b0100,
        aluSrl  = 4'b0101,
        aluOr   = 4'b0110,
        aluAnd  = 4'b0111,
        aluSub  = 4'b1000,
        aluSra  = 4'b1101
    } aluOpT;

    // which value lands in rd
    typedef enum logic [1:0] {
        srcAlu   = 2'b00,
        srcImm   = 2'b01,
        srcPcImm = 2'b10
    } resultSrcT;

    // decode to execute payload
    typedef struct packed {
        wordT              opA;
        wordT              opB;
        wordT              imm;
        logic              useImm;
        aluOpT             aluOp;
        resultSrcT         resultSrc;
        logic              isBranch;
        branchCodeT        branchCode;
        regAddrT           rd;
        logic              regWrite;
        logic [pcMaxW-1:0] pc;
    } execReqT;

    // execute to result payload
    typedef struct packed {
        regAddrT           rd;
        logic              regWrite;
        wordT              value;
        logic              branchTaken;
        logic [pcMaxW-1:0] branchTarget;
    } wbReqT;

endpackage

`default_nettype wire

// File: decode/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import rvPkg::*; #(
    parameter int pcWidth = 16
) (
    input  instrT              instr,
    input  logic [pcWidth-1:0] pc,
    output regAddrT            rdAddrA,
    output regAddrT            rdAddrB,
    input  wordT               rdDataA,
    input  wordT               rdDataB,
    output execReqT            execReq
);

    logic [6:0] opcode;
    regAddrT    rd;
    regAddrT    rs1;
    regAddrT    rs2;
    branchCodeT funct3;
    logic       bit30;
    wordT       immI;
    wordT       immU;
    wordT       immB;

    // fixed field positions, shared by every format
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign bit30  = instr[30];

    // immediates, all sign-extended from bit 31
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immU = {instr[31:12], 12'b0};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        // start from a no-op, x0 on both read ports and nothing enabled
        rdAddrA            = '0;
        rdAddrB            = '0;
        execReq.imm        = '0;
        execReq.useImm     = 1'b0;
        execReq.aluOp      = aluAdd;
        execReq.resultSrc  = srcAlu;
        execReq.isBranch   = 1'b0;
        execReq.regWrite   = 1'b0;
        execReq.rd         = '0;
        case (opcode)
            opR: begin
                rdAddrA          = rs1;
                rdAddrB          = rs2;
                // bit 30 picks sub and sra
                execReq.aluOp    = aluOpT'({bit30, funct3});
                execReq.rd       = rd;
                execReq.regWrite = 1'b1;
            end
            opImm: begin
                rdAddrA          = rs1;
                execReq.imm      = immI;
                execReq.useImm   = 1'b1;
                // only the right shift looks at bit 30 (srli vs srai)
                execReq.aluOp    = (funct3 == 3'b101) ? aluOpT'({bit30, funct3})
                                                      : aluOpT'({1'b0, funct3});
                execReq.rd       = rd;
                execReq.regWrite = 1'b1;
            end
            opLui: begin
                execReq.imm       = immU;
                execReq.resultSrc = srcImm;
                execReq.rd        = rd;
                execReq.regWrite  = 1'b1;
            end
            opAuipc: begin
                execReq.imm       = immU;
                execReq.resultSrc = srcPcImm;
                execReq.rd        = rd;
                execReq.regWrite  = 1'b1;
            end
            opBranch: begin
                // compare rs1 against rs2, the condition itself is resolved in execute
                rdAddrA          = rs1;
                rdAddrB          = rs2;
                execReq.imm      = immB;
                execReq.isBranch = 1'b1;
            end
            default: begin
                // unknown opcode stays a no-op
            end
        endcase
        // writes to x0 are dropped here once and for all
        if (execReq.rd == '0) begin
            execReq.regWrite = 1'b0;
        end
        execReq.opA        = rdDataA;
        execReq.opB        = rdDataB;
        execReq.branchCode = funct3;
        execReq.pc         = pcMaxW'(pc);
    end

endmodule

`default_nettype wire

// File: execute/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit import rvPkg::*; (
    input  wordT  a,
    input  wordT  b,
    input  aluOpT aluOp,
    output wordT  y
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    // shift amount is the low five bits for both R and I forms
    assign shamt = b[4:0];

    assign ltSigned   = ($signed(a) < $signed(b));
    assign ltUnsigned = (a < b);

    always_comb begin
        case (aluOp)
            aluAdd:  y = a + b;
            aluSub:  y = a - b;
            aluSll:  y = a << shamt;
            aluSlt:  y = {{(xlen-1){1'b0}}, ltSigned};
            aluSltu: y = {{(xlen-1){1'b0}}, ltUnsigned};
            aluXor:  y = a ^ b;
            aluSrl:  y = a >> shamt;
            // arithmetic shift keeps the sign bit
            aluSra:  y = wordT'($signed(a) >>> shamt);
            aluOr:   y = a | b;
            aluAnd:  y = a & b;
            // codes outside the enum (bit 30 set on a non sub/sra op) fall back to add
            default: y = a + b;
        endcase
    end

endmodule

`default_nettype wire

// File: execute/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit import rvPkg::*; #(
    parameter int pcWidth = 16
) (
    input  logic    inValid,
    input  execReqT execReq,
    output logic    outValid,
    output wbReqT   wbReq
);

    wordT               aluB;
    wordT               aluY;
    wordT               pcImmSum;
    logic [pcWidth-1:0] target;
    logic               cond;

    // second ALU operand is the register or the immediate
    assign aluB = execReq.useImm ? execReq.imm : execReq.opB;

    aluUnit u_aluUnit (
        .a     (execReq.opA),
        .b     (aluB),
        .aluOp (execReq.aluOp),
        .y     (aluY)
    );

    // branch compare works directly on the two register operands
    always_comb begin
        case (execReq.branchCode)
            3'b000:  cond = (execReq.opA == execReq.opB);
            3'b001:  cond = (execReq.opA != execReq.opB);
            3'b100:  cond = ($signed(execReq.opA) < $signed(execReq.opB));
            3'b101:  cond = ($signed(execReq.opA) >= $signed(execReq.opB));
            3'b110:  cond = (execReq.opA < execReq.opB);
            3'b111:  cond = (execReq.opA >= execReq.opB);
            // 010 and 011 never branch
            default: cond = 1'b0;
        endcase
    end

    // target wraps at pcWidth
    assign target   = execReq.pc[pcWidth-1:0] + execReq.imm[pcWidth-1:0];
    // auipc adds the zero-extended pc to the upper immediate
    assign pcImmSum = wordT'(execReq.pc[pcWidth-1:0]) + execReq.imm;

    assign outValid = inValid;

    always_comb begin
        wbReq.rd           = execReq.rd;
        wbReq.regWrite     = execReq.regWrite;
        wbReq.branchTaken  = execReq.isBranch & cond;
        wbReq.branchTarget = pcMaxW'(target);
        case (execReq.resultSrc)
            srcImm:   wbReq.value = execReq.imm;
            srcPcImm: wbReq.value = pcImmSum;
            default:  wbReq.value = aluY;
        endcase
    end

endmodule

`default_nettype wire

// File: rvExec.f
common/rvPkg.sv
src/stageReg.sv
src/regFile.sv
execute/aluUnit.sv
execute/execUnit.sv
decode/instrDecoder.sv
src/rvExecTop.sv
testbench/rvExec_properties.sv
testbench/tbRvExec.sv

// File: src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import rvPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  regAddrT rdAddrA,
    input  regAddrT rdAddrB,
    output wordT    rdDataA,
    output wordT    rdDataB,
    input  logic    wrEn,
    input  regAddrT wrAddr,
    input  wordT    wrData
);

    // x0 has no storage
    wordT regs [1:31];
    logic wrLive;

    assign wrLive = wrEn && (wrAddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // same-cycle write is forwarded so decode sees it before the edge
    assign rdDataA = (rdAddrA == '0)                      ? '0     :
                     (wrLive && (wrAddr == rdAddrA))      ? wrData :
                                                            regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0)                      ? '0     :
                     (wrLive && (wrAddr == rdAddrB))      ? wrData :
                                                            regs[rdAddrB];

endmodule

`default_nettype wire

// File: src/rvExecTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecTop import rvPkg::*; #(
    parameter int pcWidth = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               instrValid,
    input  instrT              instr,
    input  logic [pcWidth-1:0] pc,
    output logic               resultValid,
    output logic               resultWrite,
    output regAddrT            resultRd,
    output wordT               resultValue,
    output logic               branchTaken,
    output logic [pcWidth-1:0] branchTarget
);

    regAddrT rdAddrA;
    regAddrT rdAddrB;
    wordT    rdDataA;
    wordT    rdDataB;
    execReqT execReqD;
    execReqT execReqQ;
    logic    execValidQ;
    wbReqT   wbReqD;
    logic    wbValidD;
    wbReqT   wbReqQ;

    // decode step, reads the register file combinationally
    instrDecoder #(.pcWidth(pcWidth)) u_instrDecoder (
        .instr   (instr),
        .pc      (pc),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .execReq (execReqD)
    );

    regFile u_regFile (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (resultWrite),
        .wrAddr  (wbReqQ.rd),
        .wrData  (wbReqQ.value)
    );

    // decode to execute boundary
    stageReg #(.payloadT(execReqT)) u_execStage (
        .clk      (clk),
        .rst      (rst),
        .inValid  (instrValid),
        .inData   (execReqD),
        .outValid (execValidQ),
        .outData  (execReqQ)
    );

    execUnit #(.pcWidth(pcWidth)) u_execUnit (
        .inValid  (execValidQ),
        .execReq  (execReqQ),
        .outValid (wbValidD),
        .wbReq    (wbReqD)
    );

    // execute to result boundary, its output is the result step
    stageReg #(.payloadT(wbReqT)) u_wbStage (
        .clk      (clk),
        .rst      (rst),
        .inValid  (wbValidD),
        .inData   (wbReqD),
        .outValid (resultValid),
        .outData  (wbReqQ)
    );

    // payload holds the last instruction, so strobes are qualified by valid
    assign resultWrite  = resultValid & wbReqQ.regWrite;
    assign branchTaken  = resultValid & wbReqQ.branchTaken;
    assign resultRd     = wbReqQ.rd;
    assign resultValue  = wbReqQ.value;
    assign branchTarget = wbReqQ.branchTarget[pcWidth-1:0];

endmodule

`default_nettype wire

// File: src/stageReg.sv
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    // valid bit follows the strobe one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // payload only moves with a strobe
    always_ff @(posedge clk) begin
        if (inValid) begin
            outData <= inData;
        end
    end

endmodule

`default_nettype wire

// File: testbench/rvExec_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecProperties import rvPkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    instrValid,
    input logic    resultValid,
    input logic    resultWrite,
    input regAddrT resultRd,
    input logic    branchTaken
);

    // number of assertion failures seen so far
    int failCount = 0;

    // latency is fixed at two edges in both directions
    strobeToResult: assert property (@(posedge clk) disable iff (rst)
        instrValid |-> ##2 resultValid)
    else begin
        failCount++;
        $error("resultValid missing two cycles after instrValid");
    end

    resultFromStrobe: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> $past(instrValid, 2))
    else begin
        failCount++;
        $error("resultValid without instrValid two cycles before");
    end

    // write and taken strobes never overlap in one result
    writeOrBranch: assert property (@(posedge clk) disable iff (rst)
        resultWrite |-> !branchTaken)
    else begin
        failCount++;
        $error("resultWrite and branchTaken high together");
    end

    noWriteToX0: assert property (@(posedge clk) disable iff (rst)
        resultWrite |-> (resultRd != '0))
    else begin
        failCount++;
        $error("resultWrite with resultRd of zero");
    end

endmodule

bind rvExecTop rvExecProperties u_rvExecProperties (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .resultValid (resultValid),
    .resultWrite (resultWrite),
    .resultRd    (resultRd),
    .branchTaken (branchTaken)
);

`default_nettype wire

// File: testbench/tbRvExec.sv
`timescale 1ns/1ps
`default_nettype none

module tbRvExec import rvPkg::*; ();

    localparam int pcW = 16;
    // instructions issued by all tests together, two cycles each
    localparam int plannedInstr = 16 + 40 + 27 + 8 + 46 + 7;
    localparam int cycleLimit   = 3 * plannedInstr + 100;

    logic           clk;
    logic           rst;
    logic           instrValid;
    instrT          instr;
    logic [pcW-1:0] pc;
    logic           resultValid;
    logic           resultWrite;
    regAddrT        resultRd;
    wordT           resultValue;
    logic           branchTaken;
    logic [pcW-1:0] branchTarget;

    // shadow copy of the architectural registers
    wordT shadow [32];
    int   checks;
    int   mismatches;
    int   cycles;

    rvExecTop #(.pcWidth(pcW)) u_rvExecTop (
        .clk          (clk),
        .rst          (rst),
        .instrValid   (instrValid),
        .instr        (instr),
        .pc           (pc),
        .resultValid  (resultValid),
        .resultWrite  (resultWrite),
        .resultRd     (resultRd),
        .resultValue  (resultValue),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    always #10 clk = ~clk;

    // watchdog against a hung run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkAddr(input string name, input regAddrT got, input regAddrT exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // instruction encoders, straight from the ISA formats
    function automatic instrT encR(input logic alt, input regAddrT rs2, input regAddrT rs1,
                                   input logic [2:0] f3, input regAddrT rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opR};
    endfunction

    function automatic instrT encI(input logic [11:0] imm, input regAddrT rs1,
                                   input logic [2:0] f3, input regAddrT rd);
        return {imm, rs1, f3, rd, opImm};
    endfunction

    function automatic instrT encU(input logic [6:0] op, input logic [19:0] imm,
                                   input regAddrT rd);
        return {imm, rd, op};
    endfunction

    function automatic instrT encB(input logic [12:0] imm, input regAddrT rs2,
                                   input regAddrT rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic regAddrT randReg();
        return regAddrT'($urandom % 31 + 1);
    endfunction

    // sources come from the loaded registers x1..x8
    function automatic regAddrT srcReg();
        return regAddrT'($urandom % 8 + 1);
    endfunction

    // integer ops by funct3, alt is instruction bit 30
    function automatic wordT aluRef(input logic [2:0] f3, input logic alt,
                                    input wordT a, input wordT b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input wordT a, input wordT b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // strobe one instruction, then check its result two cycles later
    task automatic issue(input instrT ins, input logic [pcW-1:0] p);
        logic [6:0]     op;
        regAddrT        rd;
        wordT           a;
        wordT           b;
        wordT           immI;
        wordT           immU;
        wordT           immB;
        logic           expWrite;
        logic           expTaken;
        wordT           expValue;
        logic [pcW-1:0] expTarget;
        op        = ins[6:0];
        rd        = ins[11:7];
        a         = shadow[ins[19:15]];
        b         = shadow[ins[24:20]];
        immI      = {{20{ins[31]}}, ins[31:20]};
        immU      = {ins[31:12], 12'b0};
        immB      = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        expWrite  = (op inside {opR, opImm, opLui, opAuipc}) && (rd != '0);
        expTaken  = (op == opBranch) && branchRef(ins[14:12], a, b);
        expTarget = p + immB[pcW-1:0];
        case (op)
            opR:     expValue = aluRef(ins[14:12], ins[30], a, b);
            // only srai looks at bit 30
            opImm:   expValue = aluRef(ins[14:12], ins[30] && (ins[14:12] == 3'b101), a, immI);
            opLui:   expValue = immU;
            opAuipc: expValue = wordT'(p) + immU;
            default: expValue = '0;
        endcase
        instrValid = 1'b1;
        instr      = ins;
        pc         = p;
        @(negedge clk);
        instrValid = 1'b0;
        checkBit("resultValid", resultValid, 1'b0);
        @(negedge clk);
        checkBit("resultValid", resultValid, 1'b1);
        checkBit("resultWrite", resultWrite, expWrite);
        checkBit("branchTaken", branchTaken, expTaken);
        if (expWrite) begin
            checkAddr("resultRd", resultRd, rd);
            checkWord("resultValue", resultValue, expValue);
            shadow[rd] = expValue;
        end
        if (op == opBranch) begin
            checkWord("branchTarget", wordT'(branchTarget), wordT'(expTarget));
        end
    endtask

    task automatic loadReg(input regAddrT rd, input wordT value);
        logic [19:0] upper;
        // addi sign-extends its immediate so the upper part rounds up
        upper = value[31:12] + 20'(value[11]);
        issue(encU(opLui, upper, rd), pcW'($urandom));
        issue(encI(value[11:0], rd, 3'b000, rd), pcW'($urandom));
    endtask

    task automatic idleCheck();
        repeat (10) begin
            @(negedge clk);
            checkBit("resultValid", resultValid, 1'b0);
            checkBit("resultWrite", resultWrite, 1'b0);
            checkBit("branchTaken", branchTaken, 1'b0);
        end
    endtask

    task automatic rTypeOps();
        logic [2:0] f3;
        for (int r = 1; r <= 8; r++) begin
            loadReg(regAddrT'(r), $urandom);
        end
        repeat (4) begin
            // slots 8 and 9 are sub and sra
            for (int k = 0; k < 10; k++) begin
                f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
                issue(encR(k >= 8, srcReg(), srcReg(), f3, randReg()), pcW'($urandom));
            end
        end
    endtask

    task automatic immOps();
        logic [2:0]  f3;
        logic [11:0] imm;
        repeat (3) begin
            for (int k = 0; k < 9; k++) begin
                // slot 8 is srai
                f3  = (k < 8) ? 3'(k) : 3'b101;
                imm = 12'($urandom) | 12'h800;
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {1'b0, k == 8, 5'b0, imm[4:0]};
                end
                issue(encI(imm, srcReg(), f3, randReg()), pcW'($urandom));
            end
        end
    endtask

    task automatic upperOps();
        repeat (4) begin
            issue(encU(opLui, 20'($urandom), randReg()), pcW'($urandom));
            issue(encU(opAuipc, 20'($urandom), randReg()), pcW'($urandom));
        end
    endtask

    task automatic branchOps();
        // equal, smaller, larger, then x12 negative so signed and unsigned disagree
        logic [24:0] lhsList = {5'd10, 5'd10, 5'd11, 5'd12, 5'd10};
        logic [24:0] rhsList = {5'd10, 5'd11, 5'd10, 5'd10, 5'd12};
        wordT        base;
        base = $urandom & 32'h00ff_ffff;
        loadReg(5'd10, base);
        loadReg(5'd11, base | 32'h4000_0000);
        loadReg(5'd12, base | 32'h8000_0000);
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < 5; k++) begin
                issue(encB(13'($urandom) & 13'h1ffe, rhsList[5*k +: 5], lhsList[5*k +: 5],
                           3'(f)), pcW'($urandom));
            end
        end
    endtask

    task automatic x0Ops();
        issue(encI(12'($urandom), srcReg(), 3'b000, 5'd0), pcW'($urandom));
        issue(encR(1'b0, srcReg(), srcReg(), 3'b000, 5'd0), pcW'($urandom));
        issue(encU(opLui, 20'($urandom), 5'd0), pcW'($urandom));
        // load and jal opcodes are not decoded
        issue({25'($urandom), 7'b0000011}, pcW'($urandom));
        issue({25'($urandom), 7'b1101111}, pcW'($urandom));
        // x0 still reads back as zero
        issue(encR(1'b0, 5'd0, 5'd0, 3'b000, 5'd5), pcW'($urandom));
        issue(encI(12'h000, 5'd0, 3'b110, 5'd6), pcW'($urandom));
    endtask

    initial begin
        void'($urandom(32'h166e));
        clk        = 1'b0;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idleCheck();
        rTypeOps();
        immOps();
        upperOps();
        branchOps();
        x0Ops();
        $display("checks %0d, mismatches %0d, assertion failures %0d, cycles %0d",
                 checks, mismatches, u_rvExecTop.u_rvExecProperties.failCount, cycles);
        if (mismatches == 0 && u_rvExecTop.u_rvExecProperties.failCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
